// File: logic/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width.
`define LSU_XLEN 32

// depth of the data RAM in 32-bit words.
`define LSU_RAM_WORDS 256

// idle cycles between address accept and response valid, 0 to 3.
`define LSU_RAM_DELAY 1

`endif

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// funct3 encodings of the load and store instructions.
	typedef enum logic [2:0] {
		op_byte   = 3'd0,
		op_half   = 3'd1,
		op_word   = 3'd2,
		op_byte_u = 3'd4,
		op_half_u = 3'd5
	} mem_op_t;

	// bus sequencer state.
	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/lsu_request.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_request import lsu_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   lsu_valid,
	input  wire [3:0]             rd,
	input  wire                   reg_wen,
	input  wire mem_op_t          funct3,
	input  wire [`LSU_XLEN-1:0]   exu_val,
	input  wire [`LSU_XLEN-1:0]   lsu_data,
	input  wire                   lsu_ren,
	input  wire                   lsu_wen,
	input  wire                   lsu_done,
	output logic                  lsu_ready,
	output logic                  req_fire,
	output logic [3:0]            req_rd,
	output logic                  req_reg_wen,
	output mem_op_t               req_op,
	output logic [`LSU_XLEN-1:0]  req_addr,
	output logic                  req_ren,
	output logic                  req_wen,
	output logic [`LSU_XLEN/8-1:0] wstrb,
	output logic [`LSU_XLEN-1:0]  wdata
);

	logic [3:0]           rd_q;
	logic                 reg_wen_q;
	mem_op_t              op_q;
	logic [`LSU_XLEN-1:0] addr_q;
	logic [`LSU_XLEN-1:0] data_q;
	logic                 ren_q;
	logic                 wen_q;
	logic [2:0]           op_bits;
	logic [`LSU_XLEN-1:0] store_data;
	logic [`LSU_XLEN/8-1:0] size_mask;

	assign req_fire = lsu_valid & lsu_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			lsu_ready <= 1'b1;
		end else if (lsu_done) begin
			lsu_ready <= 1'b1;
		end else if (req_fire) begin
			lsu_ready <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			rd_q      <= rd;
			reg_wen_q <= reg_wen;
			op_q      <= funct3;
			addr_q    <= exu_val;
			data_q    <= lsu_data;
			ren_q     <= lsu_ren;
			wen_q     <= lsu_wen;
		end
	end

	// fields are visible in the transfer cycle itself so that a
	// pass-through request can complete without waiting.
	assign req_rd      = req_fire ? rd : rd_q;
	assign req_reg_wen = req_fire ? reg_wen : reg_wen_q;
	assign req_op      = req_fire ? funct3 : op_q;
	assign req_addr    = req_fire ? exu_val : addr_q;
	assign req_ren     = req_fire ? lsu_ren : ren_q;
	assign req_wen     = req_fire ? lsu_wen : wen_q;
	assign store_data  = req_fire ? lsu_data : data_q;

	assign op_bits = req_op;

	always_comb begin
		case (op_bits[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	assign wstrb = size_mask << req_addr[1:0];
	assign wdata = store_data << {req_addr[1:0], 3'b000};

	a_aligned: assert property (@(posedge clock) disable iff (reset)
		req_fire && (req_ren || req_wen) |->
			!(op_bits[1:0] == 2'b01 && req_addr[0]) &&
			!(op_bits[1:0] == 2'b10 && req_addr[1:0] != 2'b00));

endmodule

`default_nettype wire

// File: logic/lsu_axi_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_axi_master import lsu_pkg::*; (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     req_fire,
	input  wire                     req_ren,
	input  wire                     req_wen,
	input  wire [`LSU_XLEN-1:0]     req_addr,
	input  wire mem_op_t            req_op,
	input  wire [`LSU_XLEN/8-1:0]   wstrb,
	input  wire [`LSU_XLEN-1:0]     wdata,
	input  wire                     arready,
	input  wire                     rvalid,
	input  wire [`LSU_XLEN-1:0]     rdata,
	input  wire                     awready,
	input  wire                     wready,
	input  wire                     bvalid,
	output logic [`LSU_XLEN-1:0]    araddr,
	output logic [2:0]              arsize,
	output logic                    arvalid,
	output logic                    rready,
	output logic [`LSU_XLEN-1:0]    awaddr,
	output logic [2:0]              awsize,
	output logic                    awvalid,
	output logic [`LSU_XLEN-1:0]    wdata_out,
	output logic [`LSU_XLEN/8-1:0]  wstrb_out,
	output logic                    wvalid,
	output logic                    bready,
	output logic                    lsu_done,
	output logic [`LSU_XLEN-1:0]    load_word
);

	seq_state_t state;
	logic [2:0] op_bits;

	assign op_bits = req_op;

	// ########################################################################
	// channel sequencing
	// ########################################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= st_idle;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (req_fire && req_ren) begin
						arvalid <= 1'b1;
						state   <= st_read;
					end else if (req_fire && req_wen) begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= st_write;
					end
				end
				st_read: begin
					if (arvalid && arready)
						arvalid <= 1'b0;
					if (rvalid)
						state <= st_idle;
				end
				st_write: begin
					// aw and w may be taken in different cycles.
					if (awvalid && awready)
						awvalid <= 1'b0;
					if (wvalid && wready)
						wvalid <= 1'b0;
					if (bvalid)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign lsu_done = (state == st_idle && req_fire && !req_ren && !req_wen) ||
		(state == st_read && rvalid) || (state == st_write && bvalid);

	// ########################################################################
	// bus fields
	// ########################################################################

	assign araddr    = req_addr;
	assign awaddr    = req_addr;
	assign arsize    = {1'b0, op_bits[1:0]};
	assign awsize    = {1'b0, op_bits[1:0]};
	assign wdata_out = wdata;
	assign wstrb_out = wstrb;
	assign rready    = 1'b1;
	assign bready    = 1'b1;
	assign load_word = rdata;

	a_one_channel: assert property (@(posedge clock) disable iff (reset)
		!(arvalid && awvalid));

	a_ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize));

endmodule

`default_nettype wire

// File: logic/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_load_align import lsu_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   lsu_done,
	input  wire                   req_ren,
	input  wire mem_op_t          req_op,
	input  wire [`LSU_XLEN-1:0]   req_addr,
	input  wire [3:0]             req_rd,
	input  wire                   req_reg_wen,
	input  wire [`LSU_XLEN-1:0]   load_word,
	output logic [`LSU_XLEN-1:0]  wb_val,
	output logic [3:0]            rd_next,
	output logic                  reg_wen_next,
	output logic                  lsu_load,
	output logic                  wb_valid
);

	logic [`LSU_XLEN-1:0] shifted;
	logic [`LSU_XLEN-1:0] extended;

	// bring the addressed lane down to bit 0.
	assign shifted = load_word >> {req_addr[1:0], 3'b000};

	always_comb begin
		case (req_op)
			op_byte:   extended = {{24{shifted[7]}}, shifted[7:0]};
			op_half:   extended = {{16{shifted[15]}}, shifted[15:0]};
			op_byte_u: extended = {24'b0, shifted[7:0]};
			op_half_u: extended = {16'b0, shifted[15:0]};
			default:   extended = shifted;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= lsu_done;
	end

	always_ff @(posedge clock) begin
		if (lsu_done) begin
			wb_val       <= req_ren ? extended : req_addr;
			rd_next      <= req_rd;
			reg_wen_next <= req_reg_wen;
			lsu_load     <= req_ren;
		end
	end

endmodule

`default_nettype wire

// File: logic/data_ram_axi.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module data_ram_axi (
	input  wire                     clock,
	input  wire                     reset,
	input  wire [`LSU_XLEN-1:0]     araddr,
	input  wire                     arvalid,
	output logic                    arready,
	output logic [`LSU_XLEN-1:0]    rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  wire                     rready,
	input  wire [`LSU_XLEN-1:0]     awaddr,
	input  wire                     awvalid,
	output logic                    awready,
	input  wire [`LSU_XLEN-1:0]     wdata,
	input  wire [`LSU_XLEN/8-1:0]   wstrb,
	input  wire                     wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  wire                     bready
);

	localparam int idx_w = $clog2(`LSU_RAM_WORDS);
	localparam logic [1:0] resp_delay = `LSU_RAM_DELAY;

	logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
	logic r_wait, b_wait, aw_held, w_held;
	logic [1:0] r_count, b_count;
	logic [`LSU_XLEN-1:0] awaddr_q, wdata_q, wr_addr, wr_data;
	logic [`LSU_XLEN/8-1:0] wstrb_q, wr_strb;
	logic ar_fire, aw_fire, w_fire, do_write;

	assign ar_fire  = arvalid && arready;
	assign aw_fire  = awvalid && awready;
	assign w_fire   = wvalid && wready;
	assign arready  = !(r_wait || rvalid);
	assign awready  = !(aw_held || b_wait || bvalid);
	assign wready   = !(w_held || b_wait || bvalid);
	assign do_write = (aw_held || aw_fire) && (w_held || w_fire);
	assign wr_addr  = aw_held ? awaddr_q : awaddr;
	assign wr_data  = w_held ? wdata_q : wdata;
	assign wr_strb  = w_held ? wstrb_q : wstrb;
	assign rresp    = 2'b00;
	assign bresp    = 2'b00;

	// ########################################################################
	// storage
	// ########################################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `LSU_RAM_WORDS; i++)
				mem[i] <= '0;
		end else if (do_write) begin
			for (int b = 0; b < `LSU_XLEN/8; b++)
				if (wr_strb[b])
					mem[wr_addr[idx_w+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire)
			rdata <= mem[araddr[idx_w+1:2]];
		if (aw_fire)
			awaddr_q <= awaddr;
		if (w_fire) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

	// ########################################################################
	// response timing
	// ########################################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			r_wait  <= 1'b0;
			rvalid  <= 1'b0;
			r_count <= '0;
		end else if (ar_fire) begin
			r_wait  <= (resp_delay != 2'd0);
			rvalid  <= (resp_delay == 2'd0);
			r_count <= resp_delay;
		end else if (r_wait) begin
			r_count <= r_count - 2'd1;
			r_wait  <= (r_count != 2'd1);
			rvalid  <= (r_count == 2'd1);
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			b_wait  <= 1'b0;
			bvalid  <= 1'b0;
			b_count <= '0;
		end else begin
			aw_held <= (aw_held || aw_fire) && !do_write;
			w_held  <= (w_held || w_fire) && !do_write;
			if (do_write) begin
				b_wait  <= (resp_delay != 2'd0);
				bvalid  <= (resp_delay == 2'd0);
				b_count <= resp_delay;
			end else if (b_wait) begin
				b_count <= b_count - 2'd1;
				b_wait  <= (b_count != 2'd1);
				bvalid  <= (b_count == 2'd1);
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	a_r_hold: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid);

	a_b_hold: assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_top import lsu_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   lsu_valid,
	output wire                   lsu_ready,
	input  wire [3:0]             rd,
	input  wire                   reg_wen,
	input  wire mem_op_t          funct3,
	input  wire [`LSU_XLEN-1:0]   exu_val,
	input  wire [`LSU_XLEN-1:0]   lsu_data,
	input  wire                   lsu_ren,
	input  wire                   lsu_wen,
	output wire [`LSU_XLEN-1:0]   wb_val,
	output wire [3:0]             rd_next,
	output wire                   reg_wen_next,
	output wire                   lsu_load,
	output wire                   wb_valid
);

	wire req_fire, req_reg_wen, req_ren, req_wen, lsu_done;
	wire [3:0] req_rd;
	mem_op_t req_op;
	wire [`LSU_XLEN-1:0] req_addr, req_wdata, load_word;
	wire [`LSU_XLEN/8-1:0] req_wstrb, bus_wstrb;
	wire [`LSU_XLEN-1:0] araddr, rdata, awaddr, bus_wdata;
	wire arvalid, arready, rvalid, rready;
	wire awvalid, awready, wvalid, wready, bvalid, bready;

	lsu_request u_request (
		.clock(clock), .reset(reset), .lsu_valid(lsu_valid), .rd(rd),
		.reg_wen(reg_wen), .funct3(funct3), .exu_val(exu_val), .lsu_data(lsu_data),
		.lsu_ren(lsu_ren), .lsu_wen(lsu_wen), .lsu_done(lsu_done),
		.lsu_ready(lsu_ready), .req_fire(req_fire), .req_rd(req_rd),
		.req_reg_wen(req_reg_wen), .req_op(req_op), .req_addr(req_addr),
		.req_ren(req_ren), .req_wen(req_wen), .wstrb(req_wstrb), .wdata(req_wdata)
	);

	lsu_axi_master u_master (
		.clock(clock), .reset(reset), .req_fire(req_fire), .req_ren(req_ren),
		.req_wen(req_wen), .req_addr(req_addr), .req_op(req_op), .wstrb(req_wstrb),
		.wdata(req_wdata), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.awready(awready), .wready(wready), .bvalid(bvalid), .araddr(araddr),
		.arsize(), .arvalid(arvalid), .rready(rready), .awaddr(awaddr), .awsize(),
		.awvalid(awvalid), .wdata_out(bus_wdata), .wstrb_out(bus_wstrb),
		.wvalid(wvalid), .bready(bready), .lsu_done(lsu_done), .load_word(load_word)
	);

	lsu_load_align u_align (
		.clock(clock), .reset(reset), .lsu_done(lsu_done), .req_ren(req_ren),
		.req_op(req_op), .req_addr(req_addr), .req_rd(req_rd),
		.req_reg_wen(req_reg_wen), .load_word(load_word), .wb_val(wb_val),
		.rd_next(rd_next), .reg_wen_next(reg_wen_next), .lsu_load(lsu_load),
		.wb_valid(wb_valid)
	);

	data_ram_axi u_ram (
		.clock(clock), .reset(reset), .araddr(araddr), .arvalid(arvalid),
		.arready(arready), .rdata(rdata), .rresp(), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(bus_wdata),
		.wstrb(bus_wstrb), .wvalid(wvalid), .wready(wready), .bresp(),
		.bvalid(bvalid), .bready(bready)
	);

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);

	// 40 ns period.
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// reset held for the first 16 rising edges.
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: test/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*; ();

	localparam int iw = $clog2(`LSU_RAM_WORDS * 4);

	wire clock, reset;
	logic lsu_valid, reg_wen, lsu_ren, lsu_wen;
	logic [3:0] rd;
	mem_op_t funct3;
	logic [`LSU_XLEN-1:0] exu_val, lsu_data;
	wire lsu_ready, reg_wen_next, lsu_load, wb_valid;
	wire [`LSU_XLEN-1:0] wb_val;
	wire [3:0] rd_next;

	// byte image of the data RAM.
	logic [7:0] model [`LSU_RAM_WORDS * 4];

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int issued = 0;
	int wb_seen = 0;
	int last_latency = 0;
	int mark = 0;
	bit hung = 1'b0;

	clock_gen u_clock (.clock(clock), .reset(reset));

	lsu_top DUT (
		.clock(clock), .reset(reset), .lsu_valid(lsu_valid), .lsu_ready(lsu_ready),
		.rd(rd), .reg_wen(reg_wen), .funct3(funct3), .exu_val(exu_val),
		.lsu_data(lsu_data), .lsu_ren(lsu_ren), .lsu_wen(lsu_wen), .wb_val(wb_val),
		.rd_next(rd_next), .reg_wen_next(reg_wen_next), .lsu_load(lsu_load),
		.wb_valid(wb_valid)
	);

	always @(negedge clock) begin
		if (!reset && wb_valid)
			wb_seen++;
	end

	// ########################################################################
	// model and helpers
	// ########################################################################

	function automatic logic [31:0] random_word();
		return $urandom;
	endfunction

	function automatic logic [31:0] aligned_addr(input mem_op_t op, input logic [31:0] raw);
		case (op)
			op_word:             return raw & 32'hffff_fffc;
			op_half, op_half_u:  return raw & 32'hffff_fffe;
			default:             return raw;
		endcase
	endfunction

	function automatic mem_op_t pick_load_op();
		case ($urandom % 5)
			0:       return op_byte;
			1:       return op_half;
			2:       return op_word;
			3:       return op_byte_u;
			default: return op_half_u;
		endcase
	endfunction

	function automatic mem_op_t pick_store_op();
		case ($urandom % 3)
			0:       return op_byte;
			1:       return op_half;
			default: return op_word;
		endcase
	endfunction

	// loaded value built from the addressed bytes, little endian.
	function automatic logic [31:0] load_value(input mem_op_t op, input logic [31:0] addr);
		int base;
		logic [7:0] lo, hi;
		base = int'(addr[iw-1:0]);
		lo = model[base];
		hi = model[(base + 1) % (`LSU_RAM_WORDS * 4)];
		case (op)
			op_byte:   return {{24{lo[7]}}, lo};
			op_byte_u: return {24'h0, lo};
			op_half:   return {{16{hi[7]}}, hi, lo};
			op_half_u: return {16'h0, hi, lo};
			default:   return {model[base + 3], model[base + 2], hi, lo};
		endcase
	endfunction

	task automatic store_model(input mem_op_t op, input logic [31:0] addr,
			input logic [31:0] data);
		int base;
		int size;
		base = int'(addr[iw-1:0]);
		size = (op == op_byte) ? 1 : (op == op_half) ? 2 : 4;
		for (int i = 0; i < size; i++)
			model[base + i] = data[8*i +: 8];
	endtask

	task automatic compare_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s: %0s, %0d errors", tests, name,
			(errors == mark) ? "ok" : "failed", errors - mark);
		mark = errors;
	endtask

	// ########################################################################
	// one request, from drive to write-back
	// ########################################################################

	task automatic do_request(input logic ren, input logic wen, input mem_op_t op,
			input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] r;
		logic [31:0] expected;
		bit sent;
		bit done;
		int n;
		if (hung)
			return;
		r = random_word();
		expected = ren ? load_value(op, addr) : addr;
		repeat (r[6:5]) @(posedge clock);
		@(posedge clock);
		lsu_valid <= 1'b1;
		rd <= r[3:0];
		reg_wen <= r[4];
		funct3 <= op;
		exu_val <= addr;
		lsu_data <= data;
		lsu_ren <= ren;
		lsu_wen <= wen;
		sent = 1'b0;
		for (n = 0; n < 200 && !sent; n++) begin
			@(negedge clock);
			sent = lsu_ready;
		end
		if (!sent) begin
			$display("timeout: request at %h not accepted within 200 cycles", addr);
			hung = 1'b1;
			return;
		end
		// ready seen low edge to edge, so the transfer is on this edge.
		@(posedge clock);
		lsu_valid <= 1'b0;
		issued++;
		if (wen)
			store_model(op, addr, data);
		done = 1'b0;
		for (n = 1; n <= 200 && !done; n++) begin
			@(negedge clock);
			if (wb_valid) begin
				done = 1'b1;
				last_latency = n;
			end else begin
				compare_field("lsu_ready", 32'd0, 32'(lsu_ready));
			end
		end
		if (!done) begin
			$display("timeout: no wb_valid within 200 cycles for request at %h", addr);
			hung = 1'b1;
			return;
		end
		compare_field("wb_val", expected, wb_val);
		compare_field("rd_next", 32'(r[3:0]), 32'(rd_next));
		compare_field("reg_wen_next", 32'(r[4]), 32'(reg_wen_next));
		compare_field("lsu_load", 32'(ren), 32'(lsu_load));
	endtask

	// ########################################################################
	// test sequence
	// ########################################################################

	initial begin
		logic [31:0] addrs [16];
		logic [31:0] w;
		mem_op_t op;
		int n;
		lsu_valid = 1'b0;
		rd = 4'd0;
		reg_wen = 1'b0;
		funct3 = op_word;
		exu_val = '0;
		lsu_data = '0;
		lsu_ren = 1'b0;
		lsu_wen = 1'b0;
		for (int i = 0; i < `LSU_RAM_WORDS * 4; i++)
			model[i] = 8'h00;
		void'($urandom(84674));
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (reset && n < 200);
		if (reset) begin
			$display("timeout: reset never released");
			hung = 1'b1;
		end

		compare_field("wb_valid", 32'd0, 32'(wb_valid));
		compare_field("lsu_ready", 32'd1, 32'(lsu_ready));
		for (int i = 0; i < 4; i++) begin
			do_request(1'b0, 1'b0, pick_load_op(), random_word(), random_word());
			compare_field("wb_valid latency", 32'd1, last_latency);
		end
		report_test("reset and pass-through");

		for (int i = 0; i < 16; i++) begin
			addrs[i] = aligned_addr(op_word, random_word());
			do_request(1'b0, 1'b1, op_word, addrs[i], random_word());
		end
		for (int i = 0; i < 16; i++)
			do_request(1'b1, 1'b0, op_word, addrs[i], random_word());
		report_test("word store and load");

		for (int i = 0; i < 4; i++) begin
			w = aligned_addr(op_word, random_word());
			for (int k = 0; k < 4; k++) begin
				do_request(1'b0, 1'b1, op_byte, w | k, random_word());
				do_request(1'b1, 1'b0, op_word, w, random_word());
			end
			for (int k = 0; k < 2; k++) begin
				do_request(1'b0, 1'b1, op_half, w | (k * 2), random_word());
				do_request(1'b1, 1'b0, op_word, w, random_word());
			end
		end
		report_test("byte and halfword lanes");

		for (int i = 0; i < 6; i++) begin
			w = aligned_addr(op_word, random_word());
			do_request(1'b0, 1'b1, op_word, w, random_word());
			for (int k = 0; k < 4; k++) begin
				do_request(1'b1, 1'b0, op_byte, w | k, random_word());
				do_request(1'b1, 1'b0, op_byte_u, w | k, random_word());
			end
			for (int k = 0; k < 2; k++) begin
				do_request(1'b1, 1'b0, op_half, w | (k * 2), random_word());
				do_request(1'b1, 1'b0, op_half_u, w | (k * 2), random_word());
			end
		end
		report_test("sub-word load extension");

		for (int i = 0; i < 300; i++) begin
			case ($urandom % 3)
				0: do_request(1'b0, 1'b0, pick_load_op(), random_word(), random_word());
				1: begin
					op = pick_load_op();
					do_request(1'b1, 1'b0, op, aligned_addr(op, random_word()), random_word());
				end
				default: begin
					op = pick_store_op();
					do_request(1'b0, 1'b1, op, aligned_addr(op, random_word()), random_word());
				end
			endcase
		end
		repeat (4) @(negedge clock);
		compare_field("wb_valid count", issued, wb_seen);
		report_test("random mix");

		$display("tests %0d, checks %0d, errors %0d, requests %0d", tests, checks, errors,
			issued);
		if (errors == 0 && !hung) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_request.sv
logic/lsu_axi_master.sv
logic/lsu_load_align.sv
logic/data_ram_axi.sv
logic/lsu_top.sv
test/clock_gen.sv
test/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the load/store unit testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module lsu_tb \
	-f compile.f -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0
